// File: source/core_pkg.sv
// shared widths, instruction views and pipeline bundles of the four-stage core
// the data path is fixed at 64 bits; only the RV64I subset below is decoded
package core_pkg;

    localparam int xlen = 64;

    typedef enum logic [6:0] {
        op_op     = 7'b0110011,
        op_op_imm = 7'b0010011,
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_branch = 7'b1100011
    } op_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sll, alu_srl,
        alu_pass_b, alu_link, alu_beq, alu_bne
    } alu_e;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_view;
    } inst_u;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        inst_u           inst;
    } fet_bundle_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        alu_e            alu;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] off;   // branch / jump offset
    } dec_bundle_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } exe_bundle_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } red_bundle_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } com_bundle_t;

endpackage

// File: source/fetch.sv
// one word per cycle from a combinational instruction memory, always predicts not taken
// a redirect drops the word latched in the same cycle
`timescale 1ns/1ns

module fetch #(
    parameter logic [core_pkg::xlen-1:0] rst_pc = 64'h1000
)(
    input  logic                       clk,
    input  logic                       rst,
    input  core_pkg::red_bundle_t      red,
    output logic [core_pkg::xlen-1:0]  imem_addr,
    input  logic [31:0]                imem_data,
    output core_pkg::fet_bundle_t      fet
);
    import core_pkg::*;

    logic [xlen-1:0] pc;

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        fet.pc   <= pc;
        fet.inst <= imem_data;
        if (rst) begin
            pc        <= rst_pc;
            fet.valid <= 1'b0;
        end else begin
            fet.valid <= !red.valid;   // younger word squashed
            if (red.valid) begin
                pc <= red.target;
            end else begin
                pc <= pc + 64'd4;
            end
        end
    end

endmodule

// File: source/decode.sv
// decodes add/sub/logic/slt/shift, their immediate forms, lui, jal, beq and bne
// anything else becomes a pass of zero to x0; operands are forwarded so nothing stalls
`timescale 1ns/1ns

module decode (
    input  logic                      clk,
    input  logic                      rst,
    input  core_pkg::fet_bundle_t     fet,
    input  core_pkg::red_bundle_t     red,
    output logic [4:0]                rd_addr_a,
    output logic [4:0]                rd_addr_b,
    input  logic [core_pkg::xlen-1:0] rd_data_a,
    input  logic [core_pkg::xlen-1:0] rd_data_b,
    input  logic [core_pkg::xlen-1:0] exe_fwd_data,
    input  core_pkg::exe_bundle_t     exe,
    output core_pkg::dec_bundle_t     dec
);
    import core_pkg::*;

    logic [xlen-1:0] src_a, src_b;
    logic [xlen-1:0] i_imm, u_imm, j_imm, b_imm;
    logic            known;
    dec_bundle_t     nxt;

    // execute first, then the bundle being committed, then the register file
    function automatic logic [xlen-1:0] pick(input logic [4:0] src, input logic [xlen-1:0] rf,
                                             input dec_bundle_t d, input logic [xlen-1:0] fwd,
                                             input exe_bundle_t e);
        if (d.valid && d.rd != 5'd0 && d.rd == src) return fwd;
        if (e.valid && e.rd != 5'd0 && e.rd == src) return e.data;
        return rf;
    endfunction

    assign rd_addr_a = fet.inst.r_view.rs1;
    assign rd_addr_b = fet.inst.r_view.rs2;
    assign src_a = pick(rd_addr_a, rd_data_a, dec, exe_fwd_data, exe);
    assign src_b = pick(rd_addr_b, rd_data_b, dec, exe_fwd_data, exe);

    assign i_imm = {{52{fet.inst.i_view.imm[11]}}, fet.inst.i_view.imm};
    assign u_imm = {{32{fet.inst.r_view.funct7[6]}}, fet.inst.r_view.funct7,
                    fet.inst.r_view.rs2, fet.inst.r_view.rs1, fet.inst.r_view.funct3, 12'd0};
    assign j_imm = {{43{fet.inst.r_view.funct7[6]}}, fet.inst.r_view.funct7[6],
                    fet.inst.r_view.rs1, fet.inst.r_view.funct3, fet.inst.r_view.rs2[0],
                    fet.inst.r_view.funct7[5:0], fet.inst.r_view.rs2[4:1], 1'b0};
    assign b_imm = {{51{fet.inst.b_view.imm12}}, fet.inst.b_view.imm12, fet.inst.b_view.imm11,
                    fet.inst.b_view.imm10_5, fet.inst.b_view.imm4_1, 1'b0};

    always_comb begin
        nxt.valid = fet.valid && !red.valid;
        nxt.pc    = fet.pc;
        nxt.rd    = fet.inst.r_view.rd;
        nxt.alu   = alu_pass_b;
        nxt.a     = src_a;
        nxt.b     = src_b;
        nxt.off   = '0;
        known     = 1'b1;
        case (fet.inst.r_view.opcode)
            op_op: begin
                known = fet.inst.r_view.funct7 == 7'h00 ||
                        (fet.inst.r_view.funct7 == 7'h20 && fet.inst.r_view.funct3 == 3'b000);
                case (fet.inst.r_view.funct3)
                    3'b000:  nxt.alu = fet.inst.r_view.funct7[5] ? alu_sub : alu_add;
                    3'b001:  nxt.alu = alu_sll;
                    3'b010:  nxt.alu = alu_slt;
                    3'b100:  nxt.alu = alu_xor;
                    3'b101:  nxt.alu = alu_srl;
                    3'b110:  nxt.alu = alu_or;
                    3'b111:  nxt.alu = alu_and;
                    default: known = 1'b0;   // sltu
                endcase
            end
            op_op_imm: begin
                nxt.b = i_imm;
                case (fet.inst.i_view.funct3)
                    3'b000:  nxt.alu = alu_add;
                    3'b010:  nxt.alu = alu_slt;
                    3'b100:  nxt.alu = alu_xor;
                    3'b110:  nxt.alu = alu_or;
                    3'b111:  nxt.alu = alu_and;
                    default: known = 1'b0;   // shifts by immediate, sltiu
                endcase
            end
            op_lui: begin
                nxt.b = u_imm;
            end
            op_jal: begin
                nxt.alu = alu_link;
                nxt.off = j_imm;
            end
            op_branch: begin
                nxt.rd  = 5'd0;
                nxt.off = b_imm;
                case (fet.inst.b_view.funct3)
                    3'b000:  nxt.alu = alu_beq;
                    3'b001:  nxt.alu = alu_bne;
                    default: known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase
        if (!known) begin
            nxt.alu = alu_pass_b;
            nxt.rd  = 5'd0;
            nxt.b   = '0;
        end
    end

    always_ff @(posedge clk) begin
        dec <= nxt;
        if (rst) dec.valid <= 1'b0;
    end

endmodule

// File: source/regfile.sv
// x0 reads as zero; a read of the register being written sees the new value
`timescale 1ns/1ns

module regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [4:0]                rd_addr_a,
    input  logic [4:0]                rd_addr_b,
    output logic [core_pkg::xlen-1:0] rd_data_a,
    output logic [core_pkg::xlen-1:0] rd_data_b,
    input  logic                      wr_en,
    input  logic [4:0]                wr_addr,
    input  logic [core_pkg::xlen-1:0] wr_data
);
    import core_pkg::*;

    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rd_data_a = '0;
        rd_data_b = '0;
        if (rd_addr_a != 5'd0) begin
            rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
        end
        if (rd_addr_b != 5'd0) begin
            rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];
        end
    end

endmodule

// File: source/execute.sv
// single-cycle ALU and branch resolution; redirect is combinational from the decode bundle
// results headed for x0 are zeroed here
`timescale 1ns/1ns

module execute (
    input  logic                      clk,
    input  logic                      rst,
    input  core_pkg::dec_bundle_t     dec,
    output logic [core_pkg::xlen-1:0] fwd_data,
    output core_pkg::red_bundle_t     red,
    output core_pkg::exe_bundle_t     exe
);
    import core_pkg::*;

    logic [xlen-1:0] result;
    logic [xlen-1:0] data;
    logic            taken;

    always_comb begin
        taken = 1'b0;
        case (dec.alu)
            alu_add:    result = dec.a + dec.b;
            alu_sub:    result = dec.a - dec.b;
            alu_and:    result = dec.a & dec.b;
            alu_or:     result = dec.a | dec.b;
            alu_xor:    result = dec.a ^ dec.b;
            alu_slt:    result = {63'd0, $signed(dec.a) < $signed(dec.b)};
            alu_sll:    result = dec.a << dec.b[5:0];
            alu_srl:    result = dec.a >> dec.b[5:0];
            alu_pass_b: result = dec.b;
            alu_link: begin
                result = dec.pc + 64'd4;
                taken  = 1'b1;
            end
            alu_beq: begin
                result = '0;
                taken  = dec.a == dec.b;
            end
            alu_bne: begin
                result = '0;
                taken  = dec.a != dec.b;
            end
            default:    result = '0;
        endcase
    end

    assign data       = (dec.rd == 5'd0) ? '0 : result;
    assign fwd_data   = data;
    assign red.valid  = dec.valid && taken;
    assign red.target = dec.pc + dec.off;

    always_ff @(posedge clk) begin
        exe.pc   <= dec.pc;
        exe.rd   <= dec.rd;
        exe.data <= data;
        if (rst) begin
            exe.valid <= 1'b0;
        end else begin
            exe.valid <= dec.valid;
        end
    end

endmodule

// File: source/commit.sv
// register file is written at the same edge that loads the commit port
// retired counts commit-port beats and wraps at 2^64
`timescale 1ns/1ns

module commit (
    input  logic                      clk,
    input  logic                      rst,
    input  core_pkg::exe_bundle_t     exe,
    output logic                      wr_en,
    output logic [4:0]                wr_addr,
    output logic [core_pkg::xlen-1:0] wr_data,
    output core_pkg::com_bundle_t     com,
    output logic [63:0]               retired
);
    import core_pkg::*;

    assign wr_en   = exe.valid && exe.rd != 5'd0;
    assign wr_addr = exe.rd;
    assign wr_data = exe.data;

    always_ff @(posedge clk) begin
        com.pc   <= exe.pc;
        com.rd   <= exe.rd;
        com.data <= exe.data;
        if (rst) begin
            com.valid <= 1'b0;
        end else begin
            com.valid <= exe.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retired <= '0;
        end else if (com.valid) begin
            retired <= retired + 64'd1;   // one per beat seen
        end
    end

endmodule

// File: source/core_top.sv
// four-stage in-order core: fetch, decode, execute, commit
// instruction memory is external and must answer combinationally
`timescale 1ns/1ns

module core_top #(
    parameter logic [core_pkg::xlen-1:0] rst_pc = 64'h1000
)(
    input  logic                      clk,
    input  logic                      rst,
    output logic [core_pkg::xlen-1:0] imem_addr,
    input  logic [31:0]               imem_data,
    output core_pkg::com_bundle_t     com,
    output logic [63:0]               retired
);
    import core_pkg::*;

    fet_bundle_t     fet_bundle;
    dec_bundle_t     dec_bundle;
    exe_bundle_t     exe_bundle;
    red_bundle_t     red_bundle;
    logic [xlen-1:0] fwd_data;
    logic [4:0]      rd_addr_a, rd_addr_b;
    logic [xlen-1:0] rd_data_a, rd_data_b;
    logic            wr_en;
    logic [4:0]      wr_addr;
    logic [xlen-1:0] wr_data;

    fetch #(.rst_pc(rst_pc)) fet_inst (
        .clk(clk), .rst(rst), .red(red_bundle),
        .imem_addr(imem_addr), .imem_data(imem_data), .fet(fet_bundle)
    );

    decode dec_inst (
        .clk(clk), .rst(rst), .fet(fet_bundle), .red(red_bundle),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .exe_fwd_data(fwd_data), .exe(exe_bundle), .dec(dec_bundle)
    );

    regfile rf_inst (
        .clk(clk), .rst(rst),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    execute exe_inst (
        .clk(clk), .rst(rst), .dec(dec_bundle),
        .fwd_data(fwd_data), .red(red_bundle), .exe(exe_bundle)
    );

    commit com_inst (
        .clk(clk), .rst(rst), .exe(exe_bundle),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .com(com), .retired(retired)
    );

endmodule

// File: test/clock_gen.sv
// free-running 20 ns clock starting low
// rst is high at time zero and drops on the falling edge after 16 rising edges
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: test/core_props.sv
// sampled on the rising edge of clk
// bound into every core_top instance
`timescale 1ns/1ns

module core_props (
    input logic                  clk,
    input logic                  rst,
    input logic [63:0]           imem_addr,
    input core_pkg::com_bundle_t com,
    input logic [63:0]           retired
);

    int n_err = 0;   // failed property attempts

    no_commit_in_reset: assert property (@(posedge clk) rst |=> !com.valid)
        else begin
            $error("commit port valid during reset or in the cycle after it");
            n_err++;
        end

    retired_steps: assert property (@(posedge clk) disable iff (rst)
        com.valid |=> retired == $past(retired) + 64'd1)
        else begin
            $error("retired counter did not advance by one after a commit");
            n_err++;
        end

    retired_holds: assert property (@(posedge clk) disable iff (rst)
        !com.valid |=> $stable(retired))
        else begin
            $error("retired counter moved without a commit");
            n_err++;
        end

    addr_aligned: assert property (@(posedge clk) disable iff (rst)
        imem_addr[1:0] == 2'b00)
        else begin
            $error("instruction address not word aligned");
            n_err++;
        end

    x0_data_zero: assert property (@(posedge clk) disable iff (rst)
        com.rd == 5'd0 |-> com.data == 64'd0)
        else begin
            $error("commit to x0 carries nonzero data");
            n_err++;
        end

endmodule

bind core_top core_props props_i (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .com(com), .retired(retired)
);

// File: test/core_tb.sv
// runs one fixed program through core_top and checks every commit in order
// instruction memory answers combinationally; words past the program read as nops
`timescale 1ns/1ns

module core_tb;
    import core_pkg::*;

    localparam logic [63:0] rst_pc   = 64'h1000;
    localparam int          mem_size = 64;
    localparam logic [31:0] nop_word = 32'h0000_0013;   // addi x0, x0, 0

    logic        clk;
    logic        rst;
    logic [63:0] imem_addr;
    logic [31:0] imem_data;
    com_bundle_t com;
    logic [63:0] retired;

    logic [31:0] prog [0:mem_size-1];
    int          n_prog = 0;
    bit          built = 1'b0;
    string       exp_name [$];
    logic [63:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [63:0] exp_data [$];
    logic [63:0] word_idx;
    int          n_pass = 0;
    int          n_fail = 0;

    clock_gen clock_gen_i (.clk(clk), .rst(rst));

    core_top #(.rst_pc(rst_pc)) core_top_i (
        .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
        .com(com), .retired(retired)
    );

    assign word_idx  = (imem_addr - rst_pc) >> 2;
    assign imem_data = (word_idx < 64'(n_prog)) ? prog[word_idx[5:0]] : nop_word;

    // funct7 rides in imm for register ops; imm is the byte offset for jal and branches
    function automatic logic [31:0] encode(input op_e op, input int f3, input int rd,
                                           input int rs1, input int rs2, input int imm);
        logic [31:0] v;
        v = imm;
        case (op)
            op_op:     return {v[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
            op_lui:    return {v[19:0], rd[4:0], op};
            op_jal:    return {v[20], v[10:1], v[11], v[19:12], rd[4:0], op};
            op_branch: return {v[12], v[10:5], rs2[4:0], rs1[4:0], f3[2:0], v[4:1], v[11], op};
            default:   return {v[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
        endcase
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // squashed words go in the program only
    task automatic push_step(input string name, input logic [31:0] word, input bit commits,
                             input int rd, input logic [63:0] data);
        if (commits) begin
            exp_name.push_back(name);
            exp_pc.push_back(rst_pc + 64'(4 * n_prog));
            exp_rd.push_back(rd[4:0]);
            exp_data.push_back(data);
        end
        prog[n_prog] = word;
        n_prog++;
    endtask

    task automatic tally(input string name, input bit ok);
        $display("%-16s %s", name, ok ? "ok" : "failed");
        if (ok) begin
            n_pass++;
        end else begin
            n_fail++;
        end
    endtask

    task automatic check_commit(input int i);
        bit ok;
        ok = 1'b1;
        assert (com.pc === exp_pc[i]) else begin
            $display("mismatch %s pc expected %h actual %h", exp_name[i], exp_pc[i], com.pc);
            ok = 1'b0;
        end
        assert (com.rd === exp_rd[i]) else begin
            $display("mismatch %s rd expected %0d actual %0d", exp_name[i], exp_rd[i], com.rd);
            ok = 1'b0;
        end
        assert (com.data === exp_data[i]) else begin
            $display("mismatch %s data expected %h actual %h", exp_name[i], exp_data[i],
                     com.data);
            ok = 1'b0;
        end
        tally(exp_name[i], ok);
    endtask

    initial begin
        logic [31:0] seed;
        logic [11:0] imm;
        logic [63:0] sum;
        bit          ok;
        push_step("addi_pos", encode(op_op_imm, 0, 1, 0, 0, 100), 1, 1, 64'd100);
        push_step("addi_neg", encode(op_op_imm, 0, 2, 0, 0, -7), 1, 2, -64'sd7);
        push_step("addi_mix", encode(op_op_imm, 0, 3, 0, 0, 'h5a3), 1, 3, 64'h5a3);
        push_step("addi_3", encode(op_op_imm, 0, 4, 0, 0, 3), 1, 4, 64'd3);
        push_step("add", encode(op_op, 0, 5, 1, 2, 0), 1, 5, 64'd93);
        push_step("sub", encode(op_op, 0, 6, 1, 2, 'h20), 1, 6, 64'd107);
        push_step("and", encode(op_op, 7, 7, 3, 1, 0), 1, 7, 64'h020);
        push_step("or", encode(op_op, 6, 8, 3, 1, 0), 1, 8, 64'h5e7);
        push_step("xor", encode(op_op, 4, 9, 3, 1, 0), 1, 9, 64'h5c7);
        push_step("slt_true", encode(op_op, 2, 10, 2, 1, 0), 1, 10, 64'd1);
        push_step("slt_false", encode(op_op, 2, 11, 1, 2, 0), 1, 11, 64'd0);
        push_step("sll", encode(op_op, 1, 12, 1, 4, 0), 1, 12, 64'h320);
        push_step("srl", encode(op_op, 5, 13, 2, 4, 0), 1, 13, 64'h1fff_ffff_ffff_ffff);
        push_step("andi", encode(op_op_imm, 7, 14, 3, 0, 'h0f0), 1, 14, 64'h0a0);
        push_step("ori", encode(op_op_imm, 6, 15, 1, 0, 'h700), 1, 15, 64'h764);
        push_step("xori", encode(op_op_imm, 4, 16, 2, 0, -1), 1, 16, 64'd6);
        push_step("slti", encode(op_op_imm, 2, 17, 2, 0, -6), 1, 17, 64'd1);
        push_step("lui_pos", encode(op_lui, 0, 18, 0, 0, 'h12345), 1, 18, 64'h1234_5000);
        push_step("lui_neg", encode(op_lui, 0, 19, 0, 0, 'h80000), 1, 19,
                  64'hffff_ffff_8000_0000);
        push_step("dep_base", encode(op_op_imm, 0, 20, 0, 0, 5), 1, 20, 64'd5);
        push_step("dep_d1", encode(op_op_imm, 0, 21, 20, 0, 1), 1, 21, 64'd6);
        push_step("dep_d2", encode(op_op, 0, 22, 20, 21, 0), 1, 22, 64'd11);
        push_step("dep_d3", encode(op_op, 0, 23, 20, 22, 0), 1, 23, 64'd16);
        push_step("write_x0", encode(op_op_imm, 0, 0, 1, 0, 55), 1, 0, 64'd0);
        push_step("unsupported", 32'h0080_3083, 1, 0, 64'd0);   // ld x1, 8(x0)
        push_step("read_x0", encode(op_op, 0, 24, 0, 1, 0), 1, 24, 64'd100);
        push_step("bne_not_taken", encode(op_branch, 1, 0, 1, 24, 8), 1, 0, 64'd0);
        push_step("after_bne", encode(op_op_imm, 0, 26, 0, 0, 1), 1, 26, 64'd1);
        push_step("beq_taken", encode(op_branch, 0, 0, 1, 24, 12), 1, 0, 64'd0);
        push_step("", encode(op_op_imm, 0, 27, 0, 0, 77), 0, 0, 64'd0);
        push_step("", encode(op_op_imm, 0, 28, 0, 0, 88), 0, 0, 64'd0);
        push_step("beq_target", encode(op_op_imm, 0, 29, 27, 0, 2), 1, 29, 64'd2);
        push_step("jal_link", encode(op_jal, 0, 30, 0, 0, 12), 1, 30, 64'h1084);
        push_step("", encode(op_op_imm, 0, 29, 0, 0, 99), 0, 0, 64'd0);
        push_step("", encode(op_op_imm, 0, 30, 0, 0, 99), 0, 0, 64'd0);
        push_step("jal_target", encode(op_op, 0, 31, 30, 0, 0), 1, 31, 64'h1084);
        seed = 32'he84bd138;
        sum  = 64'd0;
        for (int k = 0; k < 8; k++) begin
            seed = lcg_next(seed);
            imm  = seed[31:20];
            sum  = sum + {{52{imm[11]}}, imm};   // running chain value in x9
            push_step($sformatf("rand_addi_%0d", k),
                      encode(op_op_imm, 0, 9, (k == 0) ? 0 : 9, 0, int'(imm)), 1, 9, sum);
        end
        built = 1'b1;

        wait (rst === 1'b0);
        for (int i = 0; i < exp_name.size(); i++) begin
            do begin
                @(negedge clk);
            end while (com.valid !== 1'b1);
            check_commit(i);
        end

        @(negedge clk);   // counter catches up one edge after the last beat
        ok = 1'b1;
        assert (retired === 64'(exp_name.size())) else begin
            $display("mismatch retired_count expected %0d actual %0d", exp_name.size(), retired);
            ok = 1'b0;
        end
        tally("retired_count", ok);

        ok = 1'b1;
        assert (core_top_i.props_i.n_err == 0) else begin
            $display("bound property checks failed %0d times", core_top_i.props_i.n_err);
            ok = 1'b0;
        end
        tally("properties", ok);

        $display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        wait (built);
        repeat ((n_prog + 20) * 4) @(posedge clk);
        $display("timeout: the expected commits did not all appear");
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: sources.f
source/core_pkg.sv
source/fetch.sv
source/decode.sv
source/regfile.sv
source/execute.sv
source/commit.sv
source/core_top.sv
test/clock_gen.sv
test/core_props.sv
test/core_tb.sv

// File: Bender.yml
package:
  name: rv64_core

sources:
  - source/core_pkg.sv
  - source/fetch.sv
  - source/decode.sv
  - source/regfile.sv
  - source/execute.sv
  - source/commit.sv
  - source/core_top.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/core_props.sv
      - test/core_tb.sv
